//--- src/core_pkg.sv
package core_pkg;

    // datapath and register file geometry
    localparam int xlen      = 32;
    localparam int reg_num   = 32;
    localparam int reg_idx_w = 5;

    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [xlen-1:0]      word_t;

    // instruction field positions
    localparam int opc_msb  = 31;
    localparam int opc_lsb  = 26;
    localparam int rd_msb   = 4;
    localparam int rd_lsb   = 0;
    localparam int rj_msb   = 9;
    localparam int rj_lsb   = 5;
    localparam int rk_msb   = 14;
    localparam int rk_lsb   = 10;
    // si12 is sign-extended, si20 lands in the upper bits
    localparam int si12_msb = 21;
    localparam int si12_lsb = 10;
    localparam int si20_msb = 24;
    localparam int si20_lsb = 5;

    // unlisted codes behave as a nop
    typedef enum logic [opc_msb-opc_lsb:0] {
        op_add   = 6'd1,
        op_sub   = 6'd2,
        op_and   = 6'd3,
        op_or    = 6'd4,
        op_xor   = 6'd5,
        op_slt   = 6'd6,
        op_addi  = 6'd7,
        op_lu12i = 6'd8
    } opcode_e;

    // fetched item, same shape as the fetch buffer output
    typedef struct packed {
        word_t pc;
        word_t inst;
    } inst_pkt_t;

    // decode to execute
    typedef struct packed {
        word_t    pc;
        word_t    inst;
        opcode_e  op;
        word_t    src1;
        // holds the extended immediate for addi and lu12i
        word_t    src2;
        reg_idx_t rd;
        logic     we;
    } exe_ctrl_t;

    // one register write, for forwarding and the regfile port
    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        word_t    data;
    } bypass_t;

    // writeback commit record
    typedef struct packed {
        word_t    pc;
        logic     we;
        reg_idx_t rd;
        word_t    wdata;
        word_t    inst;
    } commit_t;

endpackage

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               reset_i,
    input  core_pkg::reg_idx_t rj_idx_i,
    input  core_pkg::reg_idx_t rk_idx_i,
    output core_pkg::word_t    rj_data_o,
    output core_pkg::word_t    rk_data_o,
    input  core_pkg::bypass_t  write_i
);
    import core_pkg::*;

    // r0 has no storage
    word_t regs_q [1:reg_num-1];

    // single write port, commit order
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < reg_num; i++) begin
                regs_q[i] <= '0;
            end
        end else if (write_i.we && write_i.idx != '0) begin
            regs_q[write_i.idx] <= write_i.data;
        end
    end

    // async reads, old value during the write cycle
    assign rj_data_o = (rj_idx_i == '0) ? '0 : regs_q[rj_idx_i];
    assign rk_data_o = (rk_idx_i == '0) ? '0 : regs_q[rk_idx_i];

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                inst_valid_i,
    input  core_pkg::inst_pkt_t inst_i,
    output core_pkg::reg_idx_t  rj_idx_o,
    output core_pkg::reg_idx_t  rk_idx_o,
    input  core_pkg::word_t     rj_data_i,
    input  core_pkg::word_t     rk_data_i,
    input  core_pkg::bypass_t   ex_bypass_i,
    input  core_pkg::bypass_t   wb_bypass_i,
    output logic                exe_valid_o,
    output core_pkg::exe_ctrl_t exe_ctrl_o
);
    import core_pkg::*;

    logic      in_valid_q;
    inst_pkt_t in_q;
    opcode_e   op;
    reg_idx_t  rd;
    reg_idx_t  rj;
    reg_idx_t  rk;
    word_t     si12_ext;
    word_t     si20_ext;
    word_t     rj_val;
    word_t     rk_val;
    word_t     src2;
    logic      op_known;

    // operand pick: execute result, then writeback, then regfile
    function automatic word_t resolve(input reg_idx_t idx, input word_t rf_data,
                                      input bypass_t ex, input bypass_t wb);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (ex.we && ex.idx == idx) begin
            val = ex.data;
        end else if (wb.we && wb.idx == idx) begin
            // regfile write lands at the end of this cycle
            val = wb.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    // input register, valid only under reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        in_q <= inst_i;
    end

    // field split
    assign op = opcode_e'(in_q.inst[opc_msb:opc_lsb]);
    assign rd = in_q.inst[rd_msb:rd_lsb];
    assign rj = in_q.inst[rj_msb:rj_lsb];
    assign rk = in_q.inst[rk_msb:rk_lsb];

    // immediates
    assign si12_ext = {{(xlen-(si12_msb-si12_lsb+1)){in_q.inst[si12_msb]}},
                       in_q.inst[si12_msb:si12_lsb]};
    assign si20_ext = {in_q.inst[si20_msb:si20_lsb],
                       {(xlen-(si20_msb-si20_lsb+1)){1'b0}}};

    // regfile read ports
    assign rj_idx_o = rj;
    assign rk_idx_o = rk;

    assign rj_val = resolve(rj, rj_data_i, ex_bypass_i, wb_bypass_i);
    assign rk_val = resolve(rk, rk_data_i, ex_bypass_i, wb_bypass_i);

    // second operand and known-opcode flag
    always_comb begin
        op_known = 1'b1;
        src2     = rk_val;
        case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
                src2 = rk_val;
            end
            op_addi: begin
                src2 = si12_ext;
            end
            op_lu12i: begin
                src2 = si20_ext;
            end
            default: begin
                // nop, still commits
                op_known = 1'b0;
            end
        endcase
    end

    // execute register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            exe_valid_o <= 1'b0;
        end else begin
            exe_valid_o <= in_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        exe_ctrl_o.pc   <= in_q.pc;
        exe_ctrl_o.inst <= in_q.inst;
        exe_ctrl_o.op   <= op;
        exe_ctrl_o.src1 <= rj_val;
        exe_ctrl_o.src2 <= src2;
        exe_ctrl_o.rd   <= rd;
        // r0 writes are dropped here
        exe_ctrl_o.we   <= op_known && (rd != '0);
    end

endmodule

//--- src/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                exe_valid_i,
    input  core_pkg::exe_ctrl_t exe_ctrl_i,
    output core_pkg::bypass_t   ex_bypass_o,
    output logic                wb_valid_o,
    output core_pkg::commit_t   wb_o
);
    import core_pkg::*;

    word_t result;
    logic  lt;

    // signed compare for slt
    assign lt = $signed(exe_ctrl_i.src1) < $signed(exe_ctrl_i.src2);

    // alu
    always_comb begin
        case (exe_ctrl_i.op)
            op_add:   result = exe_ctrl_i.src1 + exe_ctrl_i.src2;
            op_sub:   result = exe_ctrl_i.src1 - exe_ctrl_i.src2;
            op_and:   result = exe_ctrl_i.src1 & exe_ctrl_i.src2;
            op_or:    result = exe_ctrl_i.src1 | exe_ctrl_i.src2;
            op_xor:   result = exe_ctrl_i.src1 ^ exe_ctrl_i.src2;
            op_slt:   result = {{(xlen-1){1'b0}}, lt};
            // immediate already extended in decode
            op_addi:  result = exe_ctrl_i.src1 + exe_ctrl_i.src2;
            op_lu12i: result = exe_ctrl_i.src2;
            default:  result = '0;
        endcase
    end

    // forward to decode in the same cycle
    assign ex_bypass_o.we   = exe_valid_i & exe_ctrl_i.we;
    assign ex_bypass_o.idx  = exe_ctrl_i.rd;
    assign ex_bypass_o.data = result;

    // writeback register input
    assign wb_valid_o = exe_valid_i;
    assign wb_o.pc    = exe_ctrl_i.pc;
    assign wb_o.we    = exe_ctrl_i.we;
    assign wb_o.rd    = exe_ctrl_i.rd;
    assign wb_o.wdata = result;
    assign wb_o.inst  = exe_ctrl_i.inst;

endmodule

//--- src/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              wb_valid_i,
    input  core_pkg::commit_t wb_i,
    output core_pkg::bypass_t rf_write_o,
    output logic              commit_valid_o,
    output core_pkg::commit_t commit_o
);
    import core_pkg::*;

    logic    valid_q;
    commit_t wb_q;

    // last stage register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= wb_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_q <= wb_i;
    end

    // regfile write, also the wb bypass into decode
    assign rf_write_o.we   = valid_q & wb_q.we;
    assign rf_write_o.idx  = wb_q.rd;
    assign rf_write_o.data = wb_q.wdata;

    // commit port, no wen outside a valid slot
    assign commit_valid_o = valid_q;
    assign commit_o.pc    = wb_q.pc;
    assign commit_o.we    = valid_q & wb_q.we;
    assign commit_o.rd    = wb_q.rd;
    assign commit_o.wdata = wb_q.wdata;
    assign commit_o.inst  = wb_q.inst;

endmodule

//--- src/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                inst_valid_i,
    input  core_pkg::inst_pkt_t inst_i,
    output logic                commit_valid_o,
    output core_pkg::commit_t   commit_o
);
    import core_pkg::*;

    // regfile read path
    reg_idx_t  rj_idx;
    reg_idx_t  rk_idx;
    word_t     rj_data;
    word_t     rk_data;
    // decode to execute
    logic      exe_valid;
    exe_ctrl_t exe_ctrl;
    // execute to writeback
    logic      wb_valid;
    commit_t   wb_pkt;
    // forwarding
    bypass_t   ex_bypass;
    bypass_t   rf_write;

    decode_stage u_decode (
        .clk         (clk),
        .reset_i     (reset_i),
        .inst_valid_i(inst_valid_i),
        .inst_i      (inst_i),
        .rj_idx_o    (rj_idx),
        .rk_idx_o    (rk_idx),
        .rj_data_i   (rj_data),
        .rk_data_i   (rk_data),
        .ex_bypass_i (ex_bypass),
        .wb_bypass_i (rf_write),
        .exe_valid_o (exe_valid),
        .exe_ctrl_o  (exe_ctrl)
    );

    regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .rj_idx_i (rj_idx),
        .rk_idx_i (rk_idx),
        .rj_data_o(rj_data),
        .rk_data_o(rk_data),
        .write_i  (rf_write)
    );

    exe_stage u_exe (
        .clk        (clk),
        .reset_i    (reset_i),
        .exe_valid_i(exe_valid),
        .exe_ctrl_i (exe_ctrl),
        .ex_bypass_o(ex_bypass),
        .wb_valid_o (wb_valid),
        .wb_o       (wb_pkt)
    );

    wb_stage u_wb (
        .clk           (clk),
        .reset_i       (reset_i),
        .wb_valid_i    (wb_valid),
        .wb_i          (wb_pkt),
        .rf_write_o    (rf_write),
        .commit_valid_o(commit_valid_o),
        .commit_o      (commit_o)
    );

endmodule

//--- test/core_tb_assert.sv
`timescale 1ns/1ps

module core_tb_assert (
    input logic              clk,
    input logic              reset_i,
    input logic              inst_valid_i,
    input logic              commit_valid_i,
    input core_pkg::commit_t commit_i
);

    // pipeline is empty in the first cycle out of reset
    a_idle_after_reset: assert property (
        @(posedge clk) $fell(reset_i) |-> !commit_valid_i
    ) else $error("commit valid set in the first cycle after reset");

    // write enable only inside a valid commit slot
    a_we_in_slot: assert property (
        @(posedge clk) disable iff (reset_i) commit_i.we |-> commit_valid_i
    ) else $error("commit write enable without commit valid");

    // fixed latency, once three clean cycles have passed
    a_latency: assert property (
        @(posedge clk) disable iff (reset_i)
        !$past(reset_i, 1) && !$past(reset_i, 2) && !$past(reset_i, 3)
        |-> commit_valid_i == $past(inst_valid_i, 3)
    ) else $error("commit valid does not follow instruction valid by three cycles");

endmodule

bind core_top core_tb_assert u_assert (
    .clk           (clk),
    .reset_i       (reset_i),
    .inst_valid_i  (inst_valid_i),
    .commit_valid_i(commit_valid_o),
    .commit_i      (commit_o)
);

//--- test/core_tb.sv
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    // one stimulus row with its expected commit
    typedef struct packed {
        commit_t exp;
        logic    no_gap;
    } row_t;

    // outstanding expectation and the cycle it must commit in
    typedef struct packed {
        commit_t     exp;
        logic [31:0] due;
    } pending_t;

    logic      clk;
    logic      reset_i;
    logic      inst_valid_i;
    inst_pkt_t inst_i;
    logic      commit_valid_o;
    commit_t   commit_o;

    row_t     table_q[$];
    pending_t pend_q[$];
    int       cyc = 0;
    int       value_errs = 0;
    int       timeout_errs = 0;
    int       proto_errs = 0;
    int       commits = 0;
    word_t    next_pc = 32'h1c00_0000;

    core_top uut (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .commit_valid_o(commit_valid_o),
        .commit_o      (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // register form
    function automatic word_t enc_r(input logic [5:0] code, input reg_idx_t rd,
                                    input reg_idx_t rj, input reg_idx_t rk);
        word_t w;
        w = '0;
        w[opc_msb:opc_lsb] = code;
        w[rd_msb:rd_lsb]   = rd;
        w[rj_msb:rj_lsb]   = rj;
        w[rk_msb:rk_lsb]   = rk;
        return w;
    endfunction

    // addi form, 12-bit immediate
    function automatic word_t enc_i12(input reg_idx_t rd, input reg_idx_t rj,
                                      input logic [11:0] imm);
        word_t w;
        w = '0;
        w[opc_msb:opc_lsb]   = op_addi;
        w[rd_msb:rd_lsb]     = rd;
        w[rj_msb:rj_lsb]     = rj;
        w[si12_msb:si12_lsb] = imm;
        return w;
    endfunction

    // lu12i form
    function automatic word_t enc_u20(input reg_idx_t rd, input logic [19:0] imm);
        word_t w;
        w = '0;
        w[opc_msb:opc_lsb]   = op_lu12i;
        w[rd_msb:rd_lsb]     = rd;
        w[si20_msb:si20_lsb] = imm;
        return w;
    endfunction

    task automatic add_row(input word_t inst, input logic we, input word_t wdata,
                           input logic no_gap);
        row_t r;
        r.exp.pc    = next_pc;
        r.exp.we    = we;
        r.exp.rd    = inst[rd_msb:rd_lsb];
        r.exp.wdata = wdata;
        r.exp.inst  = inst;
        r.no_gap    = no_gap;
        table_q.push_back(r);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic build_table();
        // each opcode on its own rd
        add_row(enc_u20(5'd1, 20'h12345), 1'b1, 32'h1234_5000, 1'b0);
        add_row(enc_i12(5'd2, 5'd0, 12'h7ff), 1'b1, 32'h0000_07ff, 1'b0);
        add_row(enc_i12(5'd3, 5'd0, 12'hfff), 1'b1, 32'hffff_ffff, 1'b0);
        add_row(enc_i12(5'd4, 5'd0, 12'h123), 1'b1, 32'h0000_0123, 1'b0);
        add_row(enc_r(op_add, 5'd5, 5'd1, 5'd2), 1'b1, 32'h1234_57ff, 1'b0);
        add_row(enc_r(op_sub, 5'd6, 5'd2, 5'd4), 1'b1, 32'h0000_06dc, 1'b0);
        add_row(enc_r(op_and, 5'd7, 5'd1, 5'd3), 1'b1, 32'h1234_5000, 1'b0);
        // overlapping bits tell or apart from xor and add
        add_row(enc_r(op_or, 5'd8, 5'd2, 5'd4), 1'b1, 32'h0000_07ff, 1'b0);
        add_row(enc_r(op_xor, 5'd9, 5'd3, 5'd2), 1'b1, 32'hffff_f800, 1'b0);
        // -1 < 0x7ff signed, and the reverse
        add_row(enc_r(op_slt, 5'd10, 5'd3, 5'd2), 1'b1, 32'h0000_0001, 1'b0);
        add_row(enc_r(op_slt, 5'd11, 5'd2, 5'd3), 1'b1, 32'h0000_0000, 1'b0);
        add_row(enc_i12(5'd12, 5'd1, 12'hff0), 1'b1, 32'h1234_4ff0, 1'b0);
        // back to back chain through the execute bypass
        add_row(enc_i12(5'd13, 5'd0, 12'h005), 1'b1, 32'h0000_0005, 1'b1);
        add_row(enc_r(op_add, 5'd14, 5'd13, 5'd13), 1'b1, 32'h0000_000a, 1'b1);
        add_row(enc_r(op_sub, 5'd15, 5'd14, 5'd13), 1'b1, 32'h0000_0005, 1'b1);
        add_row(enc_r(op_xor, 5'd16, 5'd15, 5'd14), 1'b1, 32'h0000_000f, 1'b1);
        add_row(enc_i12(5'd16, 5'd16, 12'h001), 1'b1, 32'h0000_0010, 1'b1);
        add_row(enc_r(op_slt, 5'd17, 5'd16, 5'd15), 1'b1, 32'h0000_0000, 1'b0);
        // two writes to r18, the younger one must win
        add_row(enc_i12(5'd18, 5'd0, 12'h100), 1'b1, 32'h0000_0100, 1'b1);
        add_row(enc_i12(5'd18, 5'd0, 12'h200), 1'b1, 32'h0000_0200, 1'b1);
        add_row(enc_r(op_add, 5'd19, 5'd18, 5'd0), 1'b1, 32'h0000_0200, 1'b0);
        // one and two apart, random gaps
        add_row(enc_u20(5'd20, 20'hfffff), 1'b1, 32'hffff_f000, 1'b0);
        add_row(enc_i12(5'd21, 5'd0, 12'h0ff), 1'b1, 32'h0000_00ff, 1'b0);
        add_row(enc_r(op_or, 5'd22, 5'd20, 5'd21), 1'b1, 32'hffff_f0ff, 1'b0);
        add_row(enc_r(op_sub, 5'd23, 5'd21, 5'd20), 1'b1, 32'h0000_10ff, 1'b0);
        add_row(enc_r(op_and, 5'd24, 5'd22, 5'd23), 1'b1, 32'h0000_10ff, 1'b0);
        add_row(enc_r(op_add, 5'd25, 5'd5, 5'd9), 1'b1, 32'h1234_4fff, 1'b0);
        // r0 target and a nop on r1, each followed by reads of its rd
        add_row(enc_r(op_add, 5'd0, 5'd1, 5'd2), 1'b0, 32'h1234_57ff, 1'b1);
        add_row(enc_r(op_or, 5'd27, 5'd0, 5'd0), 1'b1, 32'h0000_0000, 1'b1);
        add_row(enc_r(6'h3f, 5'd1, 5'd1, 5'd2), 1'b0, 32'h0000_0000, 1'b1);
        add_row(enc_r(op_add, 5'd26, 5'd1, 5'd0), 1'b1, 32'h1234_5000, 1'b1);
        add_row(enc_r(op_add, 5'd28, 5'd0, 5'd1), 1'b1, 32'h1234_5000, 1'b0);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        commit_t g;
        g = got;
        // wdata is don't care without a write
        if (!exp.we) begin
            g.wdata = exp.wdata;
        end
        if (g !== exp) begin
            $display("FAILED commit_o got pc=%h we=%h rd=%h wdata=%h inst=%h",
                     got.pc, got.we, got.rd, got.wdata, got.inst);
            $display("  expected pc=%h we=%h rd=%h wdata=%h inst=%h",
                     exp.pc, exp.we, exp.rd, exp.wdata, exp.inst);
            value_errs++;
        end
    endtask

    // commit monitor, mid cycle when outputs are settled
    always @(negedge clk) begin : monitor
        pending_t p;
        if (!reset_i) begin
            if (commit_valid_o === 1'b1) begin
                commits++;
                if (pend_q.size() == 0) begin
                    $display("commit of pc %h with no instruction outstanding", commit_o.pc);
                    proto_errs++;
                end else begin
                    p = pend_q.pop_front();
                    check_commit(commit_o, p.exp);
                    if (cyc != p.due) begin
                        $display("commit of pc %h came in cycle %0d instead of %0d",
                                 commit_o.pc, cyc, p.due);
                        proto_errs++;
                    end
                end
            end else if (pend_q.size() > 0 && pend_q[0].due <= cyc) begin
                // missed its slot, drop it so later ones stay aligned
                check_bit("commit_valid_o", commit_valid_o, 1'b1);
                p = pend_q.pop_front();
            end
        end
    end

    initial begin
        int       seed_ret;
        int       gap;
        int       waited;
        row_t     r;
        pending_t p;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        reset_i      = 1'b1;
        seed_ret     = $urandom(32'h77a26c5b);
        build_table();
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        // nothing presented, nothing commits
        repeat (6) begin
            @(negedge clk);
            check_bit("commit_valid_o", commit_valid_o, 1'b0);
        end
        foreach (table_q[i]) begin
            r = table_q[i];
            @(posedge clk);
            inst_valid_i <= 1'b1;
            inst_i.pc    <= r.exp.pc;
            inst_i.inst  <= r.exp.inst;
            // seen at cyc+1, commits three cycles later
            p.exp = r.exp;
            p.due = cyc + 4;
            pend_q.push_back(p);
            gap = r.no_gap ? 0 : int'($urandom % 3);
            repeat (gap) begin
                @(posedge clk);
                inst_valid_i <= 1'b0;
            end
        end
        @(posedge clk);
        inst_valid_i <= 1'b0;
        waited = 0;
        while (pend_q.size() > 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (pend_q.size() > 0) begin
            $display("timed out with %0d commits still outstanding", pend_q.size());
            timeout_errs++;
        end
        // late extra commits show up in the monitor
        repeat (5) @(negedge clk);
        if (commits != table_q.size()) begin
            $display("saw %0d commits for %0d instructions", commits, table_q.size());
            proto_errs++;
        end
        $display("errors: value %0d, timeout %0d, protocol %0d",
                 value_errs, timeout_errs, proto_errs);
        if (value_errs + timeout_errs + proto_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- src.f
src/core_pkg.sv
src/regfile.sv
src/decode_stage.sv
src/exe_stage.sv
src/wb_stage.sv
src/core_top.sv
test/core_tb_assert.sv
test/core_tb.sv

//--- Bender.yml
package:
  name: core

sources:
  - src/core_pkg.sv
  - src/regfile.sv
  - src/decode_stage.sv
  - src/exe_stage.sv
  - src/wb_stage.sv
  - src/core_top.sv
  - target: test
    files:
      - test/core_tb_assert.sv
      - test/core_tb.sv
